// ==== verilog/ex_pkg.sv ====
/*
  shared types for the execute stage of a 32-bit integer pipeline
  valid must stay the first field of each stage struct, since the
  registers split the top bit off as the valid flag
*/
package ex_pkg;

  parameter int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;     // one data word
  typedef logic [4:0]      reg_addr_t; // register file address

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_XOR  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_AND  = 5'd4,
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_SLT  = 5'd8,
    ALU_SLTU = 5'd9,
    ALU_EQ   = 5'd10,  // branch comparisons from here on
    ALU_NE   = 5'd11,
    ALU_LT   = 5'd12,
    ALU_GE   = 5'd13,
    ALU_LTU  = 5'd14,
    ALU_GEU  = 5'd15
  } alu_op_e;

  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  typedef enum logic [1:0] {
    WB_ALU   = 2'd0,  // write back the ALU result
    WB_LOAD  = 2'd1,
    WB_STORE = 2'd2,
    WB_PASS  = 2'd3   // write back data prepared in decode
  } wb_type_e;

  //////////////////////////////////////////////////////////////////////
  // stage bundles
  //////////////////////////////////////////////////////////////////////

  // decode to execute
  typedef struct packed {
    logic      valid;
    alu_op_e   alu_op;
    xlen_t     operand_a;
    xlen_t     operand_b;
    xlen_t     bt_a;          // branch target operands
    xlen_t     bt_b;
    logic      lsu_we;
    lsu_type_e lsu_type;
    xlen_t     lsu_wdata;
    logic      lsu_sign_ext;
    wb_type_e  wb_type;
    xlen_t     pc;
    logic      compressed;
    reg_addr_t rf_waddr;
    logic      rf_we;
    xlen_t     rf_wdata_id;
  } id_ex_t;

  // execute to memory
  typedef struct packed {
    logic      valid;
    xlen_t     lsu_addr;
    logic      lsu_we;
    lsu_type_e lsu_type;
    xlen_t     lsu_wdata;
    logic      lsu_sign_ext;
    wb_type_e  wb_type;
    xlen_t     pc;
    logic      compressed;
    reg_addr_t rf_waddr;
    logic      rf_we;
    xlen_t     rf_wdata;
  } ex_ma_t;

endpackage

// ==== verilog/ex_id_ex_reg.sv ====
/*
  decode to execute register, one instruction deep, no stall
  with ResetAll clear only the valid bit resets, the payload is
  undefined until the first instruction arrives
*/
`timescale 1ns/1ns

module ex_id_ex_reg #(
  parameter bit ResetAll = 1'b0
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  ex_pkg::id_ex_t id_ex_i,
  output ex_pkg::id_ex_t id_ex_o
);

  import ex_pkg::*;

  localparam int unsigned W = $bits(id_ex_t);

  if (ResetAll) begin : g_reset_all
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        id_ex_o <= '0;
      end else begin
        id_ex_o <= id_ex_i;
      end
    end
  end else begin : g_reset_valid
    logic         valid_q;
    logic [W-2:0] payload_q;  // everything below the valid bit

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= id_ex_i.valid;
      end
    end

    always_ff @(posedge clk_i) begin
      payload_q <= id_ex_i[W-2:0];
    end

    assign id_ex_o = id_ex_t'({valid_q, payload_q});
  end

endmodule

// ==== verilog/ex_alu.sv ====
/*
  single cycle integer ALU, purely combinational
  shifts use operand_b[4:0] only; result_o is zero for unknown ops
*/
`timescale 1ns/1ns

module ex_alu #(
  parameter bit BranchTargetAlu = 1'b1
) (
  input  ex_pkg::id_ex_t id_ex_i,
  output ex_pkg::xlen_t  result_o,
  output ex_pkg::xlen_t  adder_result_o,
  output logic           branch_decision_o,
  output ex_pkg::xlen_t  branch_target_o
);

  import ex_pkg::*;

  xlen_t     op_a;
  xlen_t     op_b;
  alu_op_e   op;
  logic      sub_en;
  xlen_t     adder_b;
  xlen_t     adder_sum;
  logic      is_equal;
  logic      signs_differ;
  logic      lt_signed;
  logic      lt_unsigned;
  logic      cmp_result;
  logic      is_branch;
  logic [4:0] shamt;

  assign op_a  = id_ex_i.operand_a;
  assign op_b  = id_ex_i.operand_b;
  assign op    = id_ex_i.alu_op;
  assign shamt = op_b[4:0];

  //////////////////////////////////////////////////////////////////////
  // shared adder
  //////////////////////////////////////////////////////////////////////

  // every comparison runs through the subtractor
  assign sub_en = op inside {ALU_SUB, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
                             ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};

  assign adder_b   = sub_en ? ~op_b : op_b;
  assign adder_sum = op_a + adder_b + xlen_t'(sub_en);  // two's complement on subtract

  assign adder_result_o = adder_sum;

  //////////////////////////////////////////////////////////////////////
  // comparison
  //////////////////////////////////////////////////////////////////////

  assign is_equal     = (adder_sum == '0);
  assign signs_differ = op_a[XLEN-1] ^ op_b[XLEN-1];

  // with differing signs the difference may overflow, so the sign bits decide
  assign lt_signed   = signs_differ ? op_a[XLEN-1] : adder_sum[XLEN-1];
  assign lt_unsigned = signs_differ ? op_b[XLEN-1] : adder_sum[XLEN-1];

  always_comb begin
    case (op)
      ALU_EQ:           cmp_result = is_equal;
      ALU_NE:           cmp_result = ~is_equal;
      ALU_LT, ALU_SLT:  cmp_result = lt_signed;
      ALU_GE:           cmp_result = ~lt_signed;
      ALU_LTU, ALU_SLTU: cmp_result = lt_unsigned;
      ALU_GEU:          cmp_result = ~lt_unsigned;
      default:          cmp_result = 1'b0;
    endcase
  end

  assign is_branch         = op inside {ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
  assign branch_decision_o = is_branch & cmp_result;

  //////////////////////////////////////////////////////////////////////
  // result mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op)
      ALU_ADD, ALU_SUB: result_o = adder_sum;
      ALU_XOR:          result_o = op_a ^ op_b;
      ALU_OR:           result_o = op_a | op_b;
      ALU_AND:          result_o = op_a & op_b;
      ALU_SLL:          result_o = op_a << shamt;
      ALU_SRL:          result_o = op_a >> shamt;
      ALU_SRA:          result_o = xlen_t'($signed(op_a) >>> shamt);
      // set-less-than and branch compares return the flag, zero extended
      ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
      ALU_LT, ALU_GE, ALU_LTU, ALU_GEU: result_o = xlen_t'(cmp_result);
      default:          result_o = '0;
    endcase
  end

  // branch target
  if (BranchTargetAlu) begin : g_bt_adder
    assign branch_target_o = id_ex_i.bt_a + id_ex_i.bt_b;  // carry dropped
  end else begin : g_bt_shared
    assign branch_target_o = adder_sum;                    // bt_a/bt_b ignored
  end

endmodule

// ==== verilog/ex_ma_reg.sv ====
/*
  execute to memory register with write-back data select
  write enables leave the register gated by its valid bit, so they
  read 0 after reset whatever ResetAll is
*/
`timescale 1ns/1ns

module ex_ma_reg #(
  parameter bit ResetAll = 1'b0
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  ex_pkg::id_ex_t id_ex_i,
  input  ex_pkg::xlen_t  alu_result_i,
  input  ex_pkg::xlen_t  adder_result_i,
  output ex_pkg::ex_ma_t ex_ma_o
);

  import ex_pkg::*;

  localparam int unsigned W = $bits(ex_ma_t);

  ex_ma_t ex_ma_d;
  ex_ma_t ex_ma_q;

  always_comb begin
    ex_ma_d.valid        = id_ex_i.valid;
    ex_ma_d.lsu_addr     = adder_result_i;  // base plus offset
    ex_ma_d.lsu_we       = id_ex_i.lsu_we;
    ex_ma_d.lsu_type     = id_ex_i.lsu_type;
    ex_ma_d.lsu_wdata    = id_ex_i.lsu_wdata;
    ex_ma_d.lsu_sign_ext = id_ex_i.lsu_sign_ext;
    ex_ma_d.wb_type      = id_ex_i.wb_type;
    ex_ma_d.pc           = id_ex_i.pc;
    ex_ma_d.compressed   = id_ex_i.compressed;
    ex_ma_d.rf_waddr     = id_ex_i.rf_waddr;
    ex_ma_d.rf_we        = id_ex_i.rf_we;
    ex_ma_d.rf_wdata     = (id_ex_i.wb_type == WB_ALU) ? alu_result_i : id_ex_i.rf_wdata_id;
  end

  if (ResetAll) begin : g_reset_all
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        ex_ma_q <= '0;
      end else begin
        ex_ma_q <= ex_ma_d;
      end
    end
  end else begin : g_reset_valid
    logic         valid_q;
    logic [W-2:0] payload_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= ex_ma_d.valid;
      end
    end

    always_ff @(posedge clk_i) begin
      payload_q <= ex_ma_d[W-2:0];
    end

    assign ex_ma_q = ex_ma_t'({valid_q, payload_q});
  end

  // bubbles never write
  always_comb begin
    ex_ma_o        = ex_ma_q;
    ex_ma_o.lsu_we = ex_ma_q.valid & ex_ma_q.lsu_we;
    ex_ma_o.rf_we  = ex_ma_q.valid & ex_ma_q.rf_we;
  end

endmodule

// ==== verilog/ex_block.sv ====
/*
  execute stage top: ID/EX register, ALU, EX/MA register
  there is no back-pressure so the memory stage must take every valid bundle
  branch and result outputs come straight from the ID/EX register
*/
`timescale 1ns/1ns

module ex_block #(
  parameter bit ResetAll        = 1'b0,
  parameter bit BranchTargetAlu = 1'b1
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  ex_pkg::id_ex_t id_ex_i,
  output ex_pkg::xlen_t  result_o,           // to ID, one cycle after issue
  output logic           branch_decision_o,
  output ex_pkg::xlen_t  branch_target_o,    // to IF
  output logic           ex_valid_o,
  output ex_pkg::ex_ma_t ex_ma_o             // to memory stage, two cycles after issue
);

  import ex_pkg::*;

  id_ex_t id_ex_q;
  xlen_t  alu_result;
  xlen_t  adder_result;

  ex_id_ex_reg #(
    .ResetAll(ResetAll)
  ) id_ex_reg0 (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .id_ex_i(id_ex_i),
    .id_ex_o(id_ex_q)
  );

  ex_alu #(
    .BranchTargetAlu(BranchTargetAlu)
  ) alu0 (
    .id_ex_i          (id_ex_q),
    .result_o         (alu_result),
    .adder_result_o   (adder_result),
    .branch_decision_o(branch_decision_o),
    .branch_target_o  (branch_target_o)
  );

  ex_ma_reg #(
    .ResetAll(ResetAll)
  ) ex_ma_reg0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .id_ex_i       (id_ex_q),
    .alu_result_i  (alu_result),
    .adder_result_i(adder_result),
    .ex_ma_o       (ex_ma_o)
  );

  assign result_o   = alu_result;
  assign ex_valid_o = id_ex_q.valid;  // every op completes in one cycle

endmodule

// ==== bench/ex_checker.sv ====
/*
  compares the execute stage outputs with expected values that arrive
  together with the stimulus; they are delayed 1 cycle for the branch and
  result outputs and 2 cycles for the memory bundle, checked at negedge
*/
`timescale 1ns/1ns

module ex_checker #(
  parameter int NumRows = 1
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  ex_pkg::xlen_t  result_i,          // DUT outputs
  input  logic           branch_decision_i,
  input  ex_pkg::xlen_t  branch_target_i,
  input  logic           ex_valid_i,
  input  ex_pkg::ex_ma_t ex_ma_i,
  input  int             row_i,             // -1 on idle cycles
  input  logic           exp_result_en_i,
  input  ex_pkg::xlen_t  exp_result_i,
  input  logic           exp_branch_i,
  input  ex_pkg::xlen_t  exp_target_i,
  input  ex_pkg::ex_ma_t exp_ma_i,
  input  logic           done_i,
  output int             rows_done_o,
  output int             fail_count_o,
  output logic           reported_o
);

  import ex_pkg::*;

  int     s1_row;
  int     s2_row;
  logic   s1_result_en;
  xlen_t  s1_result;
  logic   s1_branch;
  xlen_t  s1_target;
  ex_ma_t s1_ma;
  ex_ma_t s2_ma;
  int     row_errs[NumRows] = '{default: 0};
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  int     stray_errs = 0;  // errors outside any row
  int     rows_done = 0;
  bit     reported_q;

  assign rows_done_o  = rows_done;
  assign fail_count_o = fail_cnt + stray_errs;
  assign reported_o   = reported_q;

  function automatic int mismatch(input int row, input string field,
                                  input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error %0t ns: row %0d %s = %h, expected %h", $time, row, field, got, exp);
      return 1;
    end
    return 0;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // expected value pipeline mirroring the two DUT stages
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_row       <= -1;
      s2_row       <= -1;
      s1_result_en <= 1'b0;
      s1_result    <= '0;
      s1_branch    <= 1'b0;
      s1_target    <= '0;
      s1_ma        <= '0;
      s2_ma        <= '0;
    end else begin
      s1_row       <= row_i;
      s1_result_en <= exp_result_en_i;
      s1_result    <= exp_result_i;
      s1_branch    <= exp_branch_i;
      s1_target    <= exp_target_i;
      s1_ma        <= exp_ma_i;
      s2_row       <= s1_row;
      s2_ma        <= s1_ma;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // comparison half a cycle after the edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : compare
    int e1;
    int e2;
    e1 = 0;
    e2 = 0;
    if (!rst_ni) begin
      if ({ex_valid_i, ex_ma_i.valid, ex_ma_i.lsu_we, ex_ma_i.rf_we} !== 4'b0000) begin
        $display("%0t ns: a valid bit or write enable is set during reset", $time);
        stray_errs++;
      end
    end else begin
      // ID/EX side
      if (ex_valid_i !== s1_ma.valid) begin
        if (s1_ma.valid)
          $display("%0t ns: row %0d never raised ex_valid_o", $time, s1_row);
        else
          $display("%0t ns: ex_valid_o is set with no live instruction", $time);
        e1++;
      end else if (s1_ma.valid) begin
        if (s1_result_en)
          e1 += mismatch(s1_row, "result_o", result_i, s1_result);
        e1 += mismatch(s1_row, "branch_decision_o", branch_decision_i, s1_branch);
        e1 += mismatch(s1_row, "branch_target_o", branch_target_i, s1_target);
      end
      if (s1_row >= 0) row_errs[s1_row] += e1;
      else stray_errs += e1;

      // EX/MA side
      if (ex_ma_i.valid !== s2_ma.valid) begin
        if (s2_ma.valid)
          $display("%0t ns: row %0d never reached the memory stage", $time, s2_row);
        else
          $display("%0t ns: ex_ma_o.valid is set with no live instruction", $time);
        e2++;
      end else if (s2_ma.valid) begin
        e2 += mismatch(s2_row, "lsu_addr", ex_ma_i.lsu_addr, s2_ma.lsu_addr);
        e2 += mismatch(s2_row, "lsu_we", ex_ma_i.lsu_we, s2_ma.lsu_we);
        e2 += mismatch(s2_row, "lsu_type", ex_ma_i.lsu_type, s2_ma.lsu_type);
        e2 += mismatch(s2_row, "lsu_wdata", ex_ma_i.lsu_wdata, s2_ma.lsu_wdata);
        e2 += mismatch(s2_row, "lsu_sign_ext", ex_ma_i.lsu_sign_ext, s2_ma.lsu_sign_ext);
        e2 += mismatch(s2_row, "wb_type", ex_ma_i.wb_type, s2_ma.wb_type);
        e2 += mismatch(s2_row, "pc", ex_ma_i.pc, s2_ma.pc);
        e2 += mismatch(s2_row, "compressed", ex_ma_i.compressed, s2_ma.compressed);
        e2 += mismatch(s2_row, "rf_waddr", ex_ma_i.rf_waddr, s2_ma.rf_waddr);
        e2 += mismatch(s2_row, "rf_we", ex_ma_i.rf_we, s2_ma.rf_we);
        e2 += mismatch(s2_row, "rf_wdata", ex_ma_i.rf_wdata, s2_ma.rf_wdata);
      end else begin
        // a bubble may carry any payload but must not write
        e2 += mismatch(s2_row, "lsu_we", ex_ma_i.lsu_we, 1'b0);
        e2 += mismatch(s2_row, "rf_we", ex_ma_i.rf_we, 1'b0);
      end

      if (s2_row >= 0) begin
        row_errs[s2_row] += e2;
        if (row_errs[s2_row] == 0) begin
          pass_cnt++;
          $display("row %0d: pass", s2_row);
        end else begin
          fail_cnt++;
          $display("row %0d: fail, %0d mismatches", s2_row, row_errs[s2_row]);
        end
        rows_done++;
      end else begin
        stray_errs += e2;
      end
    end
  end

  always @(posedge done_i) begin
    $display("rows passed %0d, rows failed %0d, other errors %0d",
             pass_cnt, fail_cnt, stray_errs);
    reported_q = 1'b1;
  end

endmodule

// ==== bench/tb_ex_block.sv ====
/*
  testbench for the execute stage with ResetAll off and the branch
  target adder on; one table row per cycle, no stalls
*/
`timescale 1ns/1ns

module tb_ex_block;

  import ex_pkg::*;

  localparam int NumDirected = 22;
  localparam int NumRandom   = 26;
  localparam int NumRows     = NumDirected + NumRandom;

  typedef struct packed {
    id_ex_t stim;
    logic   res_en;   // result_o is defined for ADD..SLTU only
    xlen_t  result;
    logic   branch;
    xlen_t  target;
    ex_ma_t ma;
  } row_t;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  id_ex_t      id_ex_i;
  xlen_t       result;
  logic        branch_decision;
  xlen_t       branch_target;
  logic        ex_valid;
  ex_ma_t      ex_ma;
  int          row_idx;
  logic        exp_res_en;
  xlen_t       exp_result;
  logic        exp_branch;
  xlen_t       exp_target;
  ex_ma_t      exp_ma;
  logic        done;
  int          rows_done;
  int          fail_count;
  logic        reported;
  row_t        rows_q[NumRows];
  logic [31:0] rng_state = 32'd40;

  always #50 clk_i = ~clk_i;

  ex_block #(
    .ResetAll       (1'b0),
    .BranchTargetAlu(1'b1)
  ) dut0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .id_ex_i          (id_ex_i),
    .result_o         (result),
    .branch_decision_o(branch_decision),
    .branch_target_o  (branch_target),
    .ex_valid_o       (ex_valid),
    .ex_ma_o          (ex_ma)
  );

  ex_checker #(
    .NumRows(NumRows)
  ) chk0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .result_i         (result),
    .branch_decision_i(branch_decision),
    .branch_target_i  (branch_target),
    .ex_valid_i       (ex_valid),
    .ex_ma_i          (ex_ma),
    .row_i            (row_idx),
    .exp_result_en_i  (exp_res_en),
    .exp_result_i     (exp_result),
    .exp_branch_i     (exp_branch),
    .exp_target_i     (exp_target),
    .exp_ma_i         (exp_ma),
    .done_i           (done),
    .rows_done_o      (rows_done),
    .fail_count_o     (fail_count),
    .reported_o       (reported)
  );

  //////////////////////////////////////////////////////////////////////
  // expected values
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic xlen_t expect_result(input id_ex_t s);
    logic [4:0] sh;
    sh = s.operand_b[4:0];
    case (s.alu_op)
      ALU_ADD:  return s.operand_a + s.operand_b;
      ALU_SUB:  return s.operand_a - s.operand_b;
      ALU_XOR:  return s.operand_a ^ s.operand_b;
      ALU_OR:   return s.operand_a | s.operand_b;
      ALU_AND:  return s.operand_a & s.operand_b;
      ALU_SLL:  return s.operand_a << sh;
      ALU_SRL:  return s.operand_a >> sh;
      ALU_SRA:  return xlen_t'($signed(s.operand_a) >>> sh);
      ALU_SLT:  return xlen_t'($signed(s.operand_a) < $signed(s.operand_b));
      ALU_SLTU: return xlen_t'(s.operand_a < s.operand_b);
      default:  return '0;
    endcase
  endfunction

  function automatic logic expect_branch(input id_ex_t s);
    case (s.alu_op)
      ALU_EQ:  return s.operand_a == s.operand_b;
      ALU_NE:  return s.operand_a != s.operand_b;
      ALU_LT:  return $signed(s.operand_a) < $signed(s.operand_b);
      ALU_GE:  return $signed(s.operand_a) >= $signed(s.operand_b);
      ALU_LTU: return s.operand_a < s.operand_b;
      ALU_GEU: return s.operand_a >= s.operand_b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic ex_ma_t expect_ma(input id_ex_t s);
    ex_ma_t m;
    logic   sub;
    // comparisons share the subtractor, so their address is a minus b
    sub = s.alu_op inside {ALU_SUB, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
                           ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
    m.valid        = s.valid;
    m.lsu_addr     = sub ? s.operand_a - s.operand_b : s.operand_a + s.operand_b;
    m.lsu_we       = s.valid & s.lsu_we;
    m.lsu_type     = s.lsu_type;
    m.lsu_wdata    = s.lsu_wdata;
    m.lsu_sign_ext = s.lsu_sign_ext;
    m.wb_type      = s.wb_type;
    m.pc           = s.pc;
    m.compressed   = s.compressed;
    m.rf_waddr     = s.rf_waddr;
    m.rf_we        = s.valid & s.rf_we;
    m.rf_wdata     = (s.wb_type == WB_ALU) ? expect_result(s) : s.rf_wdata_id;
    return m;
  endfunction

  function automatic row_t make_row(input int idx, input logic valid, input alu_op_e op,
                                    input xlen_t a, input xlen_t b, input wb_type_e wb,
                                    input logic lsu_we, input logic rf_we);
    row_t r;
    r.stim.valid        = valid;
    r.stim.alu_op       = op;
    r.stim.operand_a    = a;
    r.stim.operand_b    = b;
    r.stim.pc           = 32'h8000_0000 + xlen_t'(idx) * 4;
    r.stim.bt_a         = r.stim.pc;
    r.stim.bt_b         = b;              // offset, may wrap past the top
    r.stim.lsu_we       = lsu_we;
    r.stim.lsu_type     = lsu_type_e'(2'(idx % 3));
    r.stim.lsu_wdata    = ~b;
    r.stim.lsu_sign_ext = idx[0];
    r.stim.wb_type      = wb;
    r.stim.compressed   = idx[1];
    r.stim.rf_waddr     = reg_addr_t'(idx) ^ 5'h15;
    r.stim.rf_we        = rf_we;
    r.stim.rf_wdata_id  = r.stim.pc + 4;
    r.res_en            = op < ALU_EQ;
    r.result            = expect_result(r.stim);
    r.branch            = expect_branch(r.stim);
    r.target            = r.stim.bt_a + r.stim.bt_b;
    r.ma                = expect_ma(r.stim);
    return r;
  endfunction

  task automatic build_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    alu_op_e     op;
    wb_type_e    wb;
    rows_q[0]  = make_row(0, 1, ALU_ADD, 32'h7fff_ffff, 32'h0000_0001, WB_ALU, 0, 1);
    rows_q[1]  = make_row(1, 1, ALU_SUB, 32'h0000_0000, 32'h0000_0001, WB_ALU, 0, 1);
    rows_q[2]  = make_row(2, 1, ALU_XOR, 32'ha5a5_a5a5, 32'hffff_0000, WB_ALU, 0, 1);
    rows_q[3]  = make_row(3, 1, ALU_OR, 32'h1234_0000, 32'h0000_5678, WB_ALU, 0, 1);
    rows_q[4]  = make_row(4, 1, ALU_AND, 32'hf0f0_f0f0, 32'h0ff0_0ff0, WB_ALU, 0, 1);
    rows_q[5]  = make_row(5, 1, ALU_SLL, 32'h0000_0001, 32'h0000_001f, WB_ALU, 0, 1);
    rows_q[6]  = make_row(6, 1, ALU_SRL, 32'h8000_0000, 32'hffff_ffff, WB_ALU, 0, 1);
    rows_q[7]  = make_row(7, 1, ALU_SRA, 32'h8000_0000, 32'h0000_001f, WB_ALU, 0, 1);
    rows_q[8]  = make_row(8, 1, ALU_SLT, 32'h8000_0000, 32'h7fff_ffff, WB_ALU, 0, 1);
    rows_q[9]  = make_row(9, 1, ALU_SLTU, 32'h8000_0000, 32'h7fff_ffff, WB_ALU, 0, 1);
    rows_q[10] = make_row(10, 1, ALU_EQ, 32'h1234_5678, 32'h1234_5678, WB_PASS, 0, 0);
    rows_q[11] = make_row(11, 1, ALU_NE, 32'h1234_5678, 32'h1234_5678, WB_PASS, 0, 0);
    rows_q[12] = make_row(12, 1, ALU_LT, 32'hffff_ffff, 32'h0000_0000, WB_PASS, 0, 0);
    rows_q[13] = make_row(13, 1, ALU_GE, 32'h8000_0000, 32'h8000_0000, WB_PASS, 0, 0);
    rows_q[14] = make_row(14, 1, ALU_LTU, 32'h0000_0000, 32'hffff_ffff, WB_PASS, 0, 0);
    rows_q[15] = make_row(15, 1, ALU_GEU, 32'hffff_ffff, 32'h0000_0000, WB_PASS, 0, 0);
    rows_q[16] = make_row(16, 1, ALU_ADD, 32'h0000_2000, 32'h0000_0010, WB_LOAD, 0, 1);
    rows_q[17] = make_row(17, 1, ALU_ADD, 32'h0000_3000, 32'hffff_fffc, WB_STORE, 1, 0);
    rows_q[18] = make_row(18, 1, ALU_ADD, 32'h0000_0001, 32'h0000_0002, WB_PASS, 0, 1);
    rows_q[19] = make_row(19, 0, ALU_ADD, 32'h0000_0005, 32'h0000_0006, WB_ALU, 1, 1);
    rows_q[20] = make_row(20, 1, ALU_ADD, 32'h0000_0000, 32'h0000_0000, WB_ALU, 0, 1);
    rows_q[21] = make_row(21, 0, ALU_ADD, 32'h0000_4000, 32'h0000_0008, WB_STORE, 1, 1);
    for (int i = NumDirected; i < NumRows; i++) begin
      rng_state = xorshift(rng_state);
      a = rng_state;
      rng_state = xorshift(rng_state);
      b = rng_state;
      rng_state = xorshift(rng_state);
      r = rng_state;
      op = alu_op_e'({1'b0, r[3:0]});
      wb = wb_type_e'(r[5:4]);
      if (op >= ALU_EQ && wb == WB_ALU) wb = WB_PASS;  // branches write no ALU value
      rows_q[i] = make_row(i, r[8:6] != 3'd0, op, a, b, wb, r[9], r[10]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic apply_row(input row_t r, input int idx);
    id_ex_i    = r.stim;
    row_idx    = idx;
    exp_res_en = r.res_en;
    exp_result = r.result;
    exp_branch = r.branch;
    exp_target = r.target;
    exp_ma     = r.ma;
  endtask

  initial begin : run
    rst_ni     = 1'b0;
    id_ex_i    = '0;
    row_idx    = -1;
    exp_res_en = 1'b0;
    exp_result = '0;
    exp_branch = 1'b0;
    exp_target = '0;
    exp_ma     = '0;
    done       = 1'b0;
    build_table();
    repeat (3) @(posedge clk_i);
    #5 rst_ni = 1'b1;
    for (int i = 0; i < NumRows; i++) begin
      @(posedge clk_i);
      #5;
      apply_row(rows_q[i], i);
    end
    @(posedge clk_i);
    #5;
    id_ex_i = '0;  // idle while the pipeline drains
    row_idx = -1;
    exp_ma  = '0;
    wait (rows_done == NumRows);
    done = 1'b1;
    wait (reported);
    if (fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    #((NumRows + 10) * 100);
    $display("timeout: the run did not finish within %0d cycles", NumRows + 10);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/ex_pkg.sv
verilog/ex_id_ex_reg.sv
verilog/ex_alu.sv
verilog/ex_ma_reg.sv
verilog/ex_block.sv
bench/ex_checker.sv
bench/tb_ex_block.sv

// ==== Bender.yml ====
package:
  name: ex_block

sources:
  - verilog/ex_pkg.sv
  - verilog/ex_id_ex_reg.sv
  - verilog/ex_alu.sv
  - verilog/ex_ma_reg.sv
  - verilog/ex_block.sv
  - target: test
    files:
      - bench/ex_checker.sv
      - bench/tb_ex_block.sv
